/* Makefile */
TOP = eeprom_ctrl_tb

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; test $$status -eq 0
	! grep -q "TEST RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* bench/eeprom_ctrl_chk.sv */
`timescale 1ns/1ps

module eeprom_ctrl_chk (
    input logic                   CLK,
    input logic                   RESET,
    input logic                   ack,
    input logic                   busy,
    input logic                   scl,
    input logic                   sda_in,
    input eeprom_pkg::bit_state_e phase
);

    ack_single: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else $error("ack high for two cycles in a row");

    // with scl high the line may only move as a start or stop
    sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda_in != $past(sda_in)) |->
            (phase == eeprom_pkg::PH_START || phase == eeprom_pkg::PH_STOP))
        else $error("sda changed while scl high outside a start or stop");

    busy_in_reset: assert property (@(posedge CLK) (RESET && $past(RESET)) |-> !busy)
        else $error("busy high during reset");

    ack_busy: assert property (@(posedge CLK) disable iff (RESET) ack |-> busy)
        else $error("ack pulse while not busy");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_chk chk_i (
    .CLK    (CLK),
    .RESET  (RESET),
    .ack    (ack),
    .busy   (busy),
    .scl    (scl),
    .sda_in (sda_in),
    .phase  (u_bit_engine.state)
);

/* bench/eeprom_ctrl_tb.sv */
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_ctrl_tb;

    localparam int     XFER_CYCLES = 200 * `EE_QUARTER;  // a read is 156 quarters plus latency
    localparam int     N_XFERS     = 54;
    localparam longint WATCHDOG_NS = (N_XFERS + 6) * XFER_CYCLES * 4 + 200;

    logic                 CLK;
    logic                 RESET;
    logic                 wr;
    logic                 rd;
    eeprom_pkg::ee_addr_t addr;
    eeprom_pkg::ee_byte_t wr_data;
    eeprom_pkg::ee_byte_t rd_data;
    logic                 busy;
    logic                 ack;
    logic                 nack;
    logic                 scl;
    logic                 sda_drive_low;
    logic                 sda;
    logic                 model_low;
    logic                 force_nack;
    eeprom_pkg::ee_byte_t shadow [0:2047];
    integer               seed;
    int                   checks;
    int                   mismatches;
    int                   failures;
    int                   ack_count = 0;

    eeprom_ctrl_top dut_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wr_data       (wr_data),
        .rd_data       (rd_data),
        .busy          (busy),
        .ack           (ack),
        .nack          (nack),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda)
    );

    eeprom_model model_i (
        .scl        (scl),
        .sda        (sda),
        .force_nack (force_nack),
        .sda_low    (model_low)
    );

    assign sda = !(sda_drive_low || model_low);  // open-drain wired-and

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    always @(negedge CLK)
        if (ack === 1'b1)
            ack_count <= ack_count + 1;

    function automatic eeprom_pkg::ee_byte_t fill_value(input eeprom_pkg::ee_addr_t a);
        return a[7:0] ^ 8'h5a ^ {a[10:8], 5'd0};
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            mismatches++;
            $display("MISMATCH at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic issue_strobe(input logic is_read, input eeprom_pkg::ee_addr_t a,
                                input eeprom_pkg::ee_byte_t d);
        int n;
        n = 0;
        while (busy === 1'b1 && n < XFER_CYCLES)
        begin
            @(negedge CLK);
            n++;
        end
        wr      = !is_read;
        rd      = is_read;
        addr    = a;
        wr_data = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic await_ack(input string what);
        int n;
        n = 0;
        while (ack !== 1'b1 && n < XFER_CYCLES)
        begin
            @(negedge CLK);
            n++;
        end
        if (ack !== 1'b1)
        begin
            failures++;
            $display("at %0t ns no ack came within %0d cycles for %s", $time, XFER_CYCLES, what);
        end
    endtask

    task automatic write_byte(input eeprom_pkg::ee_addr_t a, input eeprom_pkg::ee_byte_t d);
        issue_strobe(1'b0, a, d);
        await_ack($sformatf("write to %h", a));
        compare("nack", 32'(nack), 0);
        shadow[a] = d;
    endtask

    task automatic read_byte(input eeprom_pkg::ee_addr_t a);
        issue_strobe(1'b1, a, 8'h00);
        await_ack($sformatf("read of %h", a));
        compare("nack", 32'(nack), 0);
        compare($sformatf("rd_data[%h]", a), 32'(rd_data), 32'(shadow[a]));
    endtask

    task automatic reset_state_check();
        compare("busy", 32'(busy), 0);
        compare("ack", 32'(ack), 0);
        compare("nack", 32'(nack), 0);
        compare("scl", 32'(scl), 1);
        compare("sda_drive_low", 32'(sda_drive_low), 0);
    endtask

    task automatic block_reads();
        logic [31:0] r;
        logic [2:0]  blk;
        for (int b = 0; b < 8; b++)
        begin
            r   = $random(seed);
            blk = 3'(b);
            read_byte({blk, r[7:0]});
        end
    endtask

    task automatic random_pairs();
        logic [31:0] r;
        repeat (20)
        begin
            r = $random(seed);
            write_byte(r[10:0], r[18:11]);
            read_byte(r[10:0]);
        end
    endtask

    task automatic forced_nack_write();
        force_nack = 1'b1;
        issue_strobe(1'b0, 11'h2a7, 8'h99);
        await_ack("write with the memory refusing");
        compare("ack", 32'(ack), 1);
        compare("nack", 32'(nack), 1);
        @(negedge CLK);
        compare("nack", 32'(nack), 1);  // held until the next strobe
        compare("scl", 32'(scl), 1);
        compare("sda", 32'(sda), 1);
        force_nack = 1'b0;
        read_byte(11'h2a7);
    endtask

    task automatic strobe_while_busy();
        int first;
        issue_strobe(1'b0, 11'h5e1, 8'h3c);
        first = ack_count;
        compare("busy", 32'(busy), 1);
        wr      = 1'b1;
        wr_data = 8'hc3;
        @(negedge CLK);
        wr = 1'b0;
        await_ack("write with a second strobe");
        shadow[11'h5e1] = 8'h3c;
        repeat (XFER_CYCLES) @(negedge CLK);  // long enough for a whole second write
        compare("ack count", ack_count - first, 1);
        compare("busy", 32'(busy), 0);
        read_byte(11'h5e1);
    endtask

    initial
    begin
        seed       = 32'h4ed1;
        checks     = 0;
        mismatches = 0;
        failures   = 0;
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wr_data    = '0;
        force_nack = 1'b0;
        for (int i = 0; i < 2048; i++)
            shadow[i] = fill_value(11'(i));
        repeat (10) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        reset_state_check();
        write_byte(11'h123, 8'hc3);
        read_byte(11'h123);
        block_reads();
        random_pairs();
        forced_nack_write();
        strobe_while_busy();
        $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* bench/eeprom_model.sv */
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic force_nack,
    output logic sda_low
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } model_state_e;

    logic [7:0]   mem [0:2047];
    model_state_e state = M_IDLE;
    logic [7:0]   sr;
    logic [10:0]  ptr;
    logic [2:0]   blk;
    logic         rd_mode;
    logic         drive = 1'b0;
    logic         scl_q = 1'b1;
    int           cnt = 0;  // scl rises seen in the current 9-bit frame

    assign sda_low = drive;

    // low byte xor 5a, block bits folded into the top of the byte
    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'h5a ^ {3'(i >> 8), 5'd0};
    end

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl !== scl_q)
        begin
            scl_q = scl;
            if (scl === 1'b1)
            begin
                if (state == M_RDATA && cnt == 8 && sda === 1'b1)
                    state = M_IDLE;  // master nack ends the read
                else if (state == M_RDATA && cnt == 8)
                begin
                    ptr = ptr + 11'd1;
                    sr  = mem[ptr];
                end
                else if (state != M_IDLE && state != M_RDATA && cnt < 8)
                    sr = {sr[6:0], sda};
                if (state != M_IDLE)
                    cnt = cnt + 1;
            end
            else if (state == M_IDLE)
                drive = 1'b0;
            else if (cnt == 9)
            begin
                cnt   = 0;
                drive = 1'b0;  // release after the ninth bit
                if (state == M_CTRL && rd_mode)
                begin
                    sr    = mem[ptr];
                    state = M_RDATA;
                end
                else if (state == M_CTRL)
                    state = M_ADDR;
                else if (state == M_ADDR)
                    state = M_WDATA;
                if (state == M_RDATA)
                    drive = !sr[7];
            end
            else if (state == M_RDATA)
                drive = (cnt < 8) ? !sr[7 - cnt] : 1'b0;
            else if (cnt == 8)
            begin
                drive = 1'b1;
                case (state)
                    M_CTRL:
                        if (sr[7:4] == 4'b1010 && !force_nack)
                        begin
                            blk     = sr[3:1];
                            rd_mode = sr[0];
                        end
                        else
                        begin
                            state = M_IDLE;
                            drive = 1'b0;
                        end
                    M_ADDR:
                        ptr = {blk, sr};
                    default:
                    begin
                        mem[ptr] = sr;
                        ptr      = ptr + 11'd1;
                    end
                endcase
            end
        end
        else if (scl === 1'b1 && sda === 1'b0)
        begin
            state = M_CTRL;  // start or repeated start
            cnt   = 0;
            drive = 1'b0;
        end
        else if (scl === 1'b1 && sda === 1'b1)
            state = M_IDLE;  // stop
    end

endmodule

/* list.f */
+incdir+logic
logic/eeprom_pkg.sv
logic/eeprom_req_regs.sv
logic/eeprom_sequencer.sv
logic/eeprom_bit_engine.sv
logic/eeprom_ctrl_top.sv
bench/eeprom_model.sv
bench/eeprom_ctrl_chk.sv
bench/eeprom_ctrl_tb.sv

/* logic/eeprom_bit_engine.sv */
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_bit_engine (
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::bit_cmd_t cmd,
    input  logic                 cmd_valid,
    output eeprom_pkg::bit_rsp_t rsp,
    output logic                 scl,
    output logic                 sda_drive_low,
    input  logic                 sda_in
);

    eeprom_pkg::bit_state_e state;
    eeprom_pkg::bit_state_e cmd_ph;
    eeprom_pkg::ee_byte_t   shift;
    logic [3:0]             qcnt;
    logic [1:0]             q;     // quarter within the bit
    logic [3:0]             bcnt;  // 0..7 data, 8 acknowledge
    logic                   is_read;
    logic                   mnack;
    logic                   done_r;
    logic                   ack_r;
    logic                   tick;
    logic                   last;
    logic [1:0]             init_lvl;
    logic [1:0]             step_lvl;

    // returns {scl, drive_low} for a given quarter
    function automatic logic [1:0] levels(
        input eeprom_pkg::bit_state_e ph,
        input logic [1:0]             qq,
        input logic [3:0]             bb,
        input logic                   tx_bit,
        input logic                   rd,
        input logic                   mn,
        input logic                   cur_low
    );
        logic data_low;
        if (bb == 4'd8)
            data_low = rd && !mn;  // master ack on reads, slave owns it on writes
        else
            data_low = !rd && !tx_bit;
        case (ph)
            eeprom_pkg::PH_START:
                levels = (qq == 2'd0) ? 2'b00 : (qq == 2'd1) ? 2'b10 :
                         (qq == 2'd2) ? 2'b11 : 2'b01;
            eeprom_pkg::PH_STOP:
                levels = (qq == 2'd0) ? 2'b01 : (qq == 2'd1) ? 2'b11 : 2'b10;
            eeprom_pkg::PH_BYTE:
                levels = {(qq == 2'd1 || qq == 2'd2), (qq == 2'd0) ? data_low : cur_low};
            default:
                levels = 2'b10;
        endcase
    endfunction

    assign tick = (qcnt == `EE_QUARTER - 1);
    assign last = (q == 2'd3) && (state != eeprom_pkg::PH_BYTE || bcnt == 4'd8);

    always_comb
    begin
        case (cmd.op)
            eeprom_pkg::BIT_START: cmd_ph = eeprom_pkg::PH_START;
            eeprom_pkg::BIT_STOP:  cmd_ph = eeprom_pkg::PH_STOP;
            default:               cmd_ph = eeprom_pkg::PH_BYTE;
        endcase
    end

    assign init_lvl = levels(cmd_ph, 2'd0, 4'd0, cmd.tx_byte[7],
                             cmd.op == eeprom_pkg::BIT_READ, cmd.master_nack, sda_drive_low);
    assign step_lvl = levels(state, q + 2'd1, (q == 2'd3) ? bcnt + 4'd1 : bcnt,
                             shift[7], is_read, mnack, sda_drive_low);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= eeprom_pkg::PH_IDLE;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            done_r        <= 1'b0;
            qcnt          <= 4'd0;
            q             <= 2'd0;
            bcnt          <= 4'd0;
        end
        else
        begin
            done_r <= 1'b0;
            if (state == eeprom_pkg::PH_IDLE)
            begin
                if (cmd_valid)
                begin
                    state                <= cmd_ph;
                    {scl, sda_drive_low} <= init_lvl;
                    qcnt                 <= 4'd0;
                    q                    <= 2'd0;
                    bcnt                 <= 4'd0;
                end
            end
            else if (!tick)
                qcnt <= qcnt + 4'd1;
            else
            begin
                qcnt <= 4'd0;
                if (last)
                begin
                    state  <= eeprom_pkg::PH_IDLE;  // bus levels held until next command
                    done_r <= 1'b1;
                end
                else
                begin
                    q                    <= q + 2'd1;
                    {scl, sda_drive_low} <= step_lvl;
                    if (q == 2'd3)
                        bcnt <= bcnt + 4'd1;
                end
            end
        end
    end

    // sample at mid scl high, end of quarter 1
    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::PH_IDLE && cmd_valid)
        begin
            shift   <= cmd.tx_byte;
            is_read <= (cmd.op == eeprom_pkg::BIT_READ);
            mnack   <= cmd.master_nack;
        end
        else if (state == eeprom_pkg::PH_BYTE && tick && q == 2'd1)
        begin
            if (bcnt < 4'd8)
                shift <= {shift[6:0], sda_in};
            else
                ack_r <= !sda_in;
        end
    end

    assign rsp = '{done: done_r, rx_byte: shift, slave_ack: ack_r};

endmodule

/* logic/eeprom_consts.svh */
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// clock cycles per quarter of an scl period
// four quarters make one bit on the bus
`define EE_QUARTER 2

// 24c16 style device code, upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

// memory address width, top three bits go into the control byte
`define EE_ADDR_W 11

`endif

/* logic/eeprom_ctrl_top.sv */
`timescale 1ns/1ps

module eeprom_ctrl_top (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_byte_t wr_data,
    output eeprom_pkg::ee_byte_t rd_data,
    output logic                 busy,
    output logic                 ack,
    output logic                 nack,
    output logic                 scl,
    output logic                 sda_drive_low,
    input  logic                 sda_in
);

    eeprom_pkg::ee_req_t  req;
    eeprom_pkg::bit_cmd_t cmd;
    eeprom_pkg::bit_rsp_t rsp;
    eeprom_pkg::ee_byte_t rx_byte;
    logic                 start;
    logic                 finish;
    logic                 fail;
    logic                 cmd_valid;

    eeprom_req_regs u_req_regs (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .finish  (finish),
        .fail    (fail),
        .rx_byte (rx_byte),
        .req     (req),
        .start   (start),
        .busy    (busy),
        .ack     (ack),
        .nack    (nack),
        .rd_data (rd_data)
    );

    eeprom_sequencer u_sequencer (
        .CLK       (CLK),
        .RESET     (RESET),
        .req       (req),
        .start     (start),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .rsp       (rsp),
        .finish    (finish),
        .fail      (fail),
        .rx_byte   (rx_byte)
    );

    // bus side
    eeprom_bit_engine u_bit_engine (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .rsp           (rsp),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

/* logic/eeprom_pkg.sv */
`include "eeprom_consts.svh"

package eeprom_pkg;

    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;
    typedef logic [7:0]            ee_byte_t;

    typedef struct packed {
        logic     is_read;
        ee_addr_t addr;
        ee_byte_t data;  // write payload only
    } ee_req_t;

    typedef enum logic [1:0] {
        BIT_START,
        BIT_STOP,
        BIT_WRITE,
        BIT_READ
    } bit_op_e;

    typedef struct packed {
        bit_op_e  op;
        ee_byte_t tx_byte;
        logic     master_nack;  // read only, release sda on the ninth bit
    } bit_cmd_t;

    typedef struct packed {
        logic     done;
        ee_byte_t rx_byte;
        logic     slave_ack;
    } bit_rsp_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA_W,
        RESTART,
        CTRL_R,
        DATA_R,
        STOP,
        FINISH
    } seq_state_e;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_START,
        PH_STOP,
        PH_BYTE
    } bit_state_e;

endpackage

/* logic/eeprom_req_regs.sv */
`timescale 1ns/1ps

module eeprom_req_regs (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_byte_t wr_data,
    input  logic                 finish,
    input  logic                 fail,
    input  eeprom_pkg::ee_byte_t rx_byte,
    output eeprom_pkg::ee_req_t  req,
    output logic                 start,
    output logic                 busy,
    output logic                 ack,
    output logic                 nack,
    output eeprom_pkg::ee_byte_t rd_data
);

    logic accept;

    assign accept = (wr || rd) && !busy;  // strobes while busy are dropped

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start <= 1'b0;
            busy  <= 1'b0;
            ack   <= 1'b0;
            nack  <= 1'b0;
        end
        else
        begin
            start <= accept;
            ack   <= finish;
            if (accept)
            begin
                busy <= 1'b1;
                nack <= 1'b0;
            end
            else if (ack)
                busy <= 1'b0;  // drops one cycle after the ack pulse
            if (finish)
                nack <= fail;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req.is_read <= !wr;  // wr wins a tie
            req.addr    <= addr;
            req.data    <= wr_data;
        end
        if (finish && req.is_read)
            rd_data <= rx_byte;
    end

endmodule

/* logic/eeprom_sequencer.sv */
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_sequencer (
    input  logic                   CLK,
    input  logic                   RESET,
    input  eeprom_pkg::ee_req_t    req,
    input  logic                   start,
    output eeprom_pkg::bit_cmd_t   cmd,
    output logic                   cmd_valid,
    input  eeprom_pkg::bit_rsp_t   rsp,
    output logic                   finish,
    output logic                   fail,
    output eeprom_pkg::ee_byte_t   rx_byte
);

    eeprom_pkg::seq_state_e state;
    eeprom_pkg::seq_state_e state_n;
    eeprom_pkg::bit_cmd_t   cmd_n;
    eeprom_pkg::ee_byte_t   ctrl_w;
    eeprom_pkg::ee_byte_t   ctrl_r;
    logic                   issue;
    logic                   set_fail;
    logic                   no_ack;

    function automatic eeprom_pkg::bit_cmd_t mk_cmd(
        input eeprom_pkg::bit_op_e  op,
        input eeprom_pkg::ee_byte_t tx,
        input logic                 mn
    );
        eeprom_pkg::bit_cmd_t c;
        c.op          = op;
        c.tx_byte     = tx;
        c.master_nack = mn;
        return c;
    endfunction

    // control byte: device code, block bits, r/w
    assign ctrl_w = {`EE_DEV_CODE, req.addr[`EE_ADDR_W-1 -: 3], 1'b0};
    assign ctrl_r = {`EE_DEV_CODE, req.addr[`EE_ADDR_W-1 -: 3], 1'b1};
    assign no_ack = rsp.done && !rsp.slave_ack;

    always_comb
    begin
        state_n  = state;
        issue    = 1'b0;
        set_fail = 1'b0;
        cmd_n    = mk_cmd(eeprom_pkg::BIT_STOP, 8'hff, 1'b0);
        case (state)
            eeprom_pkg::IDLE:
                if (start)
                begin
                    state_n = eeprom_pkg::START;
                    issue   = 1'b1;
                    cmd_n   = mk_cmd(eeprom_pkg::BIT_START, 8'hff, 1'b0);
                end
            eeprom_pkg::START:
                if (rsp.done)
                begin
                    state_n = eeprom_pkg::CTRL_W;
                    issue   = 1'b1;
                    cmd_n   = mk_cmd(eeprom_pkg::BIT_WRITE, ctrl_w, 1'b0);
                end
            eeprom_pkg::CTRL_W:
                if (rsp.done)
                begin
                    issue = 1'b1;
                    if (no_ack)
                    begin
                        state_n  = eeprom_pkg::STOP;
                        set_fail = 1'b1;
                    end
                    else
                    begin
                        state_n = eeprom_pkg::ADDR;
                        cmd_n   = mk_cmd(eeprom_pkg::BIT_WRITE, req.addr[7:0], 1'b0);
                    end
                end
            eeprom_pkg::ADDR:
                if (rsp.done)
                begin
                    issue = 1'b1;
                    if (no_ack)
                    begin
                        state_n  = eeprom_pkg::STOP;
                        set_fail = 1'b1;
                    end
                    else if (req.is_read)
                    begin
                        state_n = eeprom_pkg::RESTART;
                        cmd_n   = mk_cmd(eeprom_pkg::BIT_START, 8'hff, 1'b0);
                    end
                    else
                    begin
                        state_n = eeprom_pkg::DATA_W;
                        cmd_n   = mk_cmd(eeprom_pkg::BIT_WRITE, req.data, 1'b0);
                    end
                end
            eeprom_pkg::DATA_W:
                if (rsp.done)
                begin
                    state_n  = eeprom_pkg::STOP;
                    issue    = 1'b1;
                    set_fail = no_ack;
                end
            eeprom_pkg::RESTART:
                if (rsp.done)
                begin
                    state_n = eeprom_pkg::CTRL_R;
                    issue   = 1'b1;
                    cmd_n   = mk_cmd(eeprom_pkg::BIT_WRITE, ctrl_r, 1'b0);
                end
            eeprom_pkg::CTRL_R:
                if (rsp.done)
                begin
                    issue = 1'b1;
                    if (no_ack)
                    begin
                        state_n  = eeprom_pkg::STOP;
                        set_fail = 1'b1;
                    end
                    else
                    begin
                        state_n = eeprom_pkg::DATA_R;
                        cmd_n   = mk_cmd(eeprom_pkg::BIT_READ, 8'hff, 1'b1);  // single byte
                    end
                end
            eeprom_pkg::DATA_R:
                if (rsp.done)
                begin
                    state_n = eeprom_pkg::STOP;
                    issue   = 1'b1;
                end
            eeprom_pkg::STOP:
                if (rsp.done)
                    state_n = eeprom_pkg::FINISH;
            default:
                state_n = eeprom_pkg::IDLE;  // FINISH lands here too
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::IDLE;
            cmd_valid <= 1'b0;
            finish    <= 1'b0;
            fail      <= 1'b0;
        end
        else
        begin
            state     <= state_n;
            cmd_valid <= issue;
            finish    <= (state == eeprom_pkg::FINISH);
            if (start && state == eeprom_pkg::IDLE)
                fail <= 1'b0;
            else if (set_fail)
                fail <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (issue)
            cmd <= cmd_n;
        if (state == eeprom_pkg::DATA_R && rsp.done)
            rx_byte <= rsp.rx_byte;
    end

endmodule
